// File: verilog/rob_pkg.sv
package rob_pkg;

    // buffer geometry
    localparam int ROB_DEPTH = 16;
    localparam int ROB_IDW   = 4;   // entry index
    localparam int ROB_CNTW  = 5;   // holds 0 .. ROB_DEPTH

    // lanes per stage
    localparam int DISP_W = 2;
    localparam int EXE_W  = 2;
    localparam int COM_W  = 2;

    // payload widths
    localparam int PC_W    = 64;
    localparam int CAUSE_W = 6;
    localparam int TVAL_W  = 64;

    // exception cause codes, RISC-V numbering
    localparam logic [CAUSE_W-1:0] CAUSE_INSTR_MISALIGN = 6'd0;
    localparam logic [CAUSE_W-1:0] CAUSE_INSTR_FAULT    = 6'd1;
    localparam logic [CAUSE_W-1:0] CAUSE_ILLEGAL_INSTR  = 6'd2;
    localparam logic [CAUSE_W-1:0] CAUSE_BREAKPOINT     = 6'd3;
    localparam logic [CAUSE_W-1:0] CAUSE_LOAD_MISALIGN  = 6'd4;
    localparam logic [CAUSE_W-1:0] CAUSE_LOAD_FAULT     = 6'd5;
    localparam logic [CAUSE_W-1:0] CAUSE_STORE_MISALIGN = 6'd6;
    localparam logic [CAUSE_W-1:0] CAUSE_STORE_FAULT    = 6'd7;
    localparam logic [CAUSE_W-1:0] CAUSE_ECALL_U        = 6'd8;
    localparam logic [CAUSE_W-1:0] CAUSE_ECALL_M        = 6'd11;
    localparam logic [CAUSE_W-1:0] CAUSE_INSTR_PAGE     = 6'd12;
    localparam logic [CAUSE_W-1:0] CAUSE_LOAD_PAGE      = 6'd13;
    localparam logic [CAUSE_W-1:0] CAUSE_STORE_PAGE     = 6'd15;

    // value driven on cause while no exception is taken
    localparam logic [CAUSE_W-1:0] CAUSE_NONE = '0;

endpackage

// File: verilog/rob_occupancy.sv
`timescale 1ns/1ps

module rob_occupancy
    import rob_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic [DISP_W-1:0]   disp_valid,
    input  logic [ROB_CNTW-1:0] retire_count,
    input  logic                take_exc,
    output logic                disp_ready,
    output logic [DISP_W-1:0]   alloc_en,
    output logic [ROB_IDW-1:0]  disp_id,
    output logic [ROB_IDW-1:0]  head,
    output logic [ROB_CNTW-1:0] count
);

    logic [ROB_IDW-1:0]  tail;
    logic [ROB_IDW-1:0]  head_next;
    logic [ROB_CNTW-1:0] alloc_count;
    logic                lane_gap;

    // room for a full dispatch group, and no flush in progress
    assign disp_ready = (count <= ROB_CNTW'(ROB_DEPTH - DISP_W)) && !take_exc;
    assign disp_id    = tail;                              // lane 0 id, lane 1 gets next
    assign head_next  = head + ROB_IDW'(retire_count);

    // lanes fill from 0 upward, a hole ends the group
    always_comb begin
        alloc_en    = '0;
        alloc_count = '0;
        lane_gap    = 1'b0;
        for (int i = 0; i < DISP_W; i++) begin
            if (!disp_valid[i]) begin
                lane_gap = 1'b1;
            end else if (!lane_gap && disp_ready) begin
                alloc_en[i] = 1'b1;
                alloc_count = alloc_count + ROB_CNTW'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (take_exc) begin
            // older slots still retire, everything younger is dropped
            head  <= head_next;
            tail  <= head_next;
            count <= '0;
        end else begin
            head  <= head_next;
            tail  <= tail + ROB_IDW'(alloc_count);
            count <= count + alloc_count - retire_count;
        end
    end

endmodule

// File: verilog/rob_entry_store.sv
`timescale 1ns/1ps

module rob_entry_store
    import rob_pkg::*;
(
    input  logic                            clk,
    input  logic                            rst,
    // dispatch write port
    input  logic [DISP_W-1:0]               alloc_en,
    input  logic [ROB_IDW-1:0]              disp_id,
    input  logic [DISP_W-1:0][PC_W-1:0]     disp_pc,
    // execute write port
    input  logic [EXE_W-1:0]                exe_valid,
    input  logic [EXE_W-1:0][ROB_IDW-1:0]   exe_id,
    input  logic [EXE_W-1:0]                exe_exc,
    input  logic [EXE_W-1:0][CAUSE_W-1:0]   exe_cause,
    // head window read port
    input  logic [ROB_IDW-1:0]              head,
    output logic [COM_W-1:0][PC_W-1:0]      win_pc,
    output logic [COM_W-1:0]                win_done,
    output logic [COM_W-1:0]                win_exc,
    output logic [COM_W-1:0][CAUSE_W-1:0]   win_cause
);

    logic [PC_W-1:0]      pc_mem    [ROB_DEPTH];
    logic [CAUSE_W-1:0]   cause_mem [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] done_q;
    logic [ROB_DEPTH-1:0] exc_q;
    logic [ROB_IDW-1:0]   alloc_idx [DISP_W];
    logic [ROB_IDW-1:0]   rd_idx    [COM_W];

    always_comb begin
        for (int i = 0; i < DISP_W; i++) begin
            alloc_idx[i] = disp_id + ROB_IDW'(i);          // wraps around the ring
        end
        for (int i = 0; i < COM_W; i++) begin
            rd_idx[i] = head + ROB_IDW'(i);
        end
    end

    // PC written once at allocation
    always_ff @(posedge clk) begin
        for (int i = 0; i < DISP_W; i++) begin
            if (alloc_en[i]) begin
                pc_mem[alloc_idx[i]] <= disp_pc[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < EXE_W; i++) begin
            if (exe_valid[i]) begin
                cause_mem[exe_id[i]] <= exe_cause[i];
            end
        end
    end

    // status bits, allocation clears and execute sets
    always_ff @(posedge clk) begin
        if (rst) begin
            done_q <= '0;
            exc_q  <= '0;
        end else begin
            for (int i = 0; i < DISP_W; i++) begin
                if (alloc_en[i]) begin
                    done_q[alloc_idx[i]] <= 1'b0;
                    exc_q[alloc_idx[i]]  <= 1'b0;
                end
            end
            for (int i = 0; i < EXE_W; i++) begin
                if (exe_valid[i]) begin
                    done_q[exe_id[i]] <= 1'b1;
                    exc_q[exe_id[i]]  <= exe_exc[i];
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < COM_W; i++) begin
            win_pc[i]    = pc_mem[rd_idx[i]];
            win_done[i]  = done_q[rd_idx[i]];
            win_exc[i]   = exc_q[rd_idx[i]];
            win_cause[i] = cause_mem[rd_idx[i]];
        end
    end

endmodule

// File: verilog/rob_commit_select.sv
`timescale 1ns/1ps

module rob_commit_select
    import rob_pkg::*;
(
    input  logic [ROB_CNTW-1:0]             count,
    input  logic [ROB_IDW-1:0]              head,
    input  logic [COM_W-1:0][PC_W-1:0]      win_pc,
    input  logic [COM_W-1:0]                win_done,
    input  logic [COM_W-1:0]                win_exc,
    input  logic [COM_W-1:0][CAUSE_W-1:0]   win_cause,
    // commit report
    output logic [COM_W-1:0]                com_valid,
    output logic [COM_W-1:0][ROB_IDW-1:0]   com_id,
    output logic [COM_W-1:0][PC_W-1:0]      com_pc,
    // to occupancy and trap unit
    output logic [ROB_CNTW-1:0]             retire_count,
    output logic                            take_exc,
    output logic [PC_W-1:0]                 exc_pc,
    output logic [CAUSE_W-1:0]              exc_cause
);

    logic [COM_W-1:0] in_range;     // slot holds an allocated entry
    logic [COM_W-1:0] slot_ok;      // retirable on its own
    logic [COM_W-1:0] slot_fault;   // completed with exception
    logic             stop;

    always_comb begin
        for (int i = 0; i < COM_W; i++) begin
            in_range[i]   = ROB_CNTW'(i) < count;
            slot_ok[i]    = in_range[i] && win_done[i] && !win_exc[i];
            slot_fault[i] = in_range[i] && win_done[i] && win_exc[i];
        end
    end

    // walk from the head, first blocked slot ends the group
    always_comb begin
        com_valid    = '0;
        retire_count = '0;
        take_exc     = 1'b0;
        exc_pc       = '0;
        exc_cause    = '0;
        stop         = 1'b0;
        for (int i = 0; i < COM_W; i++) begin
            com_id[i] = head + ROB_IDW'(i);
            com_pc[i] = win_pc[i];
            if (!stop) begin
                if (slot_ok[i]) begin
                    com_valid[i] = 1'b1;
                    retire_count = retire_count + ROB_CNTW'(1);
                end else begin
                    stop = 1'b1;
                    if (slot_fault[i]) begin
                        // oldest live entry faulted, older slots still go
                        take_exc  = 1'b1;
                        exc_pc    = win_pc[i];
                        exc_cause = win_cause[i];
                    end
                end
            end
        end
    end

endmodule

// File: verilog/rob_trap_unit.sv
`timescale 1ns/1ps

module rob_trap_unit
    import rob_pkg::*;
(
    input  logic                           clk,
    input  logic                           rst,
    input  logic [ROB_IDW-1:0]             head,
    input  logic [EXE_W-1:0]               exe_valid,
    input  logic [EXE_W-1:0][ROB_IDW-1:0]  exe_id,
    input  logic [EXE_W-1:0]               exe_exc,
    input  logic [EXE_W-1:0][TVAL_W-1:0]   exe_tval,
    input  logic                           take_exc,
    input  logic [PC_W-1:0]                exc_pc,
    input  logic [CAUSE_W-1:0]             exc_cause,
    output logic                           exception,
    output logic [PC_W-1:0]                epc,
    output logic [CAUSE_W-1:0]             cause,
    output logic [TVAL_W-1:0]              tval
);

    logic               pend_valid, pend_valid_next;
    logic [ROB_IDW-1:0] pend_id, pend_id_next;
    logic [TVAL_W-1:0]  pend_tval, pend_tval_next;

    // distance from head, smaller is older
    function automatic logic [ROB_IDW-1:0] age(input logic [ROB_IDW-1:0] id);
        age = id - head;
    endfunction

    // keep only the oldest excepting completion
    always_comb begin
        pend_valid_next = pend_valid;
        pend_id_next    = pend_id;
        pend_tval_next  = pend_tval;
        for (int i = 0; i < EXE_W; i++) begin
            if (exe_valid[i] && exe_exc[i]) begin
                if (!pend_valid_next || age(exe_id[i]) < age(pend_id_next)) begin
                    pend_valid_next = 1'b1;
                    pend_id_next    = exe_id[i];
                    pend_tval_next  = exe_tval[i];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || take_exc) begin
            pend_valid <= 1'b0;                            // flush drops all younger faults
        end else begin
            pend_valid <= pend_valid_next;
        end
    end

    always_ff @(posedge clk) begin
        pend_id   <= pend_id_next;
        pend_tval <= pend_tval_next;
    end

    assign exception = take_exc;
    assign epc       = take_exc ? exc_pc : '0;
    assign cause     = take_exc ? exc_cause : CAUSE_NONE;
    assign tval      = take_exc ? pend_tval : '0;          // pending entry is the faulting head

endmodule

// File: verilog/rob_top.sv
`timescale 1ns/1ps

module rob_top
    import rob_pkg::*;
(
    input  logic                           clk,
    input  logic                           rst,
    // dispatch
    input  logic [DISP_W-1:0]              disp_valid,
    input  logic [DISP_W-1:0][PC_W-1:0]    disp_pc,
    output logic                           disp_ready,
    output logic [ROB_IDW-1:0]             disp_id,
    // execute write-back
    input  logic [EXE_W-1:0]               exe_valid,
    input  logic [EXE_W-1:0][ROB_IDW-1:0]  exe_id,
    input  logic [EXE_W-1:0]               exe_exc,
    input  logic [EXE_W-1:0][CAUSE_W-1:0]  exe_cause,
    input  logic [EXE_W-1:0][TVAL_W-1:0]   exe_tval,
    // commit
    output logic [COM_W-1:0]               com_valid,
    output logic [COM_W-1:0][ROB_IDW-1:0]  com_id,
    output logic [COM_W-1:0][PC_W-1:0]     com_pc,
    // exception
    output logic                           exception,
    output logic [PC_W-1:0]                epc,
    output logic [CAUSE_W-1:0]             cause,
    output logic [TVAL_W-1:0]              tval
);

    logic [DISP_W-1:0]             alloc_en;
    logic [ROB_IDW-1:0]            head;
    logic [ROB_CNTW-1:0]           count;
    logic [ROB_CNTW-1:0]           retire_count;
    logic                          take_exc;
    logic [COM_W-1:0][PC_W-1:0]    win_pc;
    logic [COM_W-1:0]              win_done;
    logic [COM_W-1:0]              win_exc;
    logic [COM_W-1:0][CAUSE_W-1:0] win_cause;
    logic [PC_W-1:0]               exc_pc;
    logic [CAUSE_W-1:0]            exc_cause;

    rob_occupancy u_occupancy (
        .clk          (clk),
        .rst          (rst),
        .disp_valid   (disp_valid),
        .retire_count (retire_count),
        .take_exc     (take_exc),
        .disp_ready   (disp_ready),
        .alloc_en     (alloc_en),
        .disp_id      (disp_id),
        .head         (head),
        .count        (count)
    );

    rob_entry_store u_entry_store (
        .clk       (clk),
        .rst       (rst),
        .alloc_en  (alloc_en),
        .disp_id   (disp_id),
        .disp_pc   (disp_pc),
        .exe_valid (exe_valid),
        .exe_id    (exe_id),
        .exe_exc   (exe_exc),
        .exe_cause (exe_cause),
        .head      (head),
        .win_pc    (win_pc),
        .win_done  (win_done),
        .win_exc   (win_exc),
        .win_cause (win_cause)
    );

    rob_commit_select u_commit_select (
        .count        (count),
        .head         (head),
        .win_pc       (win_pc),
        .win_done     (win_done),
        .win_exc      (win_exc),
        .win_cause    (win_cause),
        .com_valid    (com_valid),
        .com_id       (com_id),
        .com_pc       (com_pc),
        .retire_count (retire_count),
        .take_exc     (take_exc),
        .exc_pc       (exc_pc),
        .exc_cause    (exc_cause)
    );

    rob_trap_unit u_trap_unit (
        .clk       (clk),
        .rst       (rst),
        .head      (head),
        .exe_valid (exe_valid),
        .exe_id    (exe_id),
        .exe_exc   (exe_exc),
        .exe_tval  (exe_tval),
        .take_exc  (take_exc),
        .exc_pc    (exc_pc),
        .exc_cause (exc_cause),
        .exception (exception),
        .epc       (epc),
        .cause     (cause),
        .tval      (tval)
    );

endmodule

// File: dv/rob_properties.sv
`timescale 1ns/1ps

module rob_properties
    import rob_pkg::*;
(
    input logic                           clk,
    input logic                           rst,
    input logic [DISP_W-1:0]              disp_valid,
    input logic [DISP_W-1:0][PC_W-1:0]    disp_pc,
    input logic                           disp_ready,
    input logic [ROB_IDW-1:0]             disp_id,
    input logic [EXE_W-1:0]               exe_valid,
    input logic [EXE_W-1:0][ROB_IDW-1:0]  exe_id,
    input logic [EXE_W-1:0]               exe_exc,
    input logic [EXE_W-1:0][CAUSE_W-1:0]  exe_cause,
    input logic [EXE_W-1:0][TVAL_W-1:0]   exe_tval,
    input logic [COM_W-1:0]               com_valid,
    input logic [COM_W-1:0][ROB_IDW-1:0]  com_id,
    input logic [COM_W-1:0][PC_W-1:0]     com_pc,
    input logic                           exception,
    input logic [PC_W-1:0]                epc,
    input logic [CAUSE_W-1:0]             cause,
    input logic [TVAL_W-1:0]              tval
);

    int fail_cnt = 0;                                      // read by the testbench summary

    // shadow ring, indexed the same way as the entry IDs
    logic [PC_W-1:0]      m_pc    [ROB_DEPTH];
    logic [CAUSE_W-1:0]   m_cause [ROB_DEPTH];
    logic [TVAL_W-1:0]    m_tval  [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] m_done;
    logic [ROB_DEPTH-1:0] m_exc;
    logic [ROB_IDW-1:0]   m_head;
    logic [ROB_IDW-1:0]   m_tail;
    logic [ROB_IDW-1:0]   exp_idx;
    int                   m_count;
    int                   exp_ncom;
    int                   n_alloc;
    logic                 exp_exc;
    logic                 exp_ready;
    logic                 stop;

    // expected retire group and trap from the head window
    always_comb begin
        exp_ncom = 0;
        exp_exc  = 1'b0;
        exp_idx  = m_head;
        stop     = 1'b0;
        for (int i = 0; i < COM_W; i++) begin
            if (!stop) begin
                exp_idx = m_head + ROB_IDW'(i);
                if (i < m_count && m_done[exp_idx] && !m_exc[exp_idx]) begin
                    exp_ncom++;
                end else begin
                    stop    = 1'b1;
                    exp_exc = i < m_count && m_done[exp_idx] && m_exc[exp_idx];
                end
            end
        end
        exp_ready = (m_count <= ROB_DEPTH - DISP_W) && !exp_exc;
        // lanes that actually transfer on the handshake
        n_alloc   = (disp_ready && disp_valid[0]) ? (disp_valid[1] ? 2 : 1) : 0;
    end

    always @(posedge clk) begin
        if (rst) begin
            m_head  <= '0;
            m_tail  <= '0;
            m_count <= 0;
            m_done  <= '0;
            m_exc   <= '0;
        end else begin
            m_head <= m_head + ROB_IDW'(exp_ncom);
            if (exp_exc) begin
                m_tail  <= m_head + ROB_IDW'(exp_ncom);    // younger entries are gone
                m_count <= 0;
            end else begin
                m_tail  <= m_tail + ROB_IDW'(n_alloc);
                m_count <= m_count + n_alloc - exp_ncom;
            end
            for (int i = 0; i < DISP_W; i++) begin
                if (i < n_alloc) begin
                    m_pc[m_tail + ROB_IDW'(i)]   <= disp_pc[i];
                    m_done[m_tail + ROB_IDW'(i)] <= 1'b0;
                    m_exc[m_tail + ROB_IDW'(i)]  <= 1'b0;
                end
            end
            for (int i = 0; i < EXE_W; i++) begin
                if (exe_valid[i]) begin
                    m_done[exe_id[i]]  <= 1'b1;
                    m_exc[exe_id[i]]   <= exe_exc[i];
                    m_cause[exe_id[i]] <= exe_cause[i];
                    m_tval[exe_id[i]]  <= exe_tval[i];
                end
            end
        end
    end

    a_reset: assert property (@(posedge clk)
        $fell(rst) |-> disp_ready && com_valid == '0 && !exception)
        else begin fail_cnt++; $error("outputs wrong right after reset"); end
    a_ready: assert property (@(posedge clk) disable iff (rst) disp_ready == exp_ready)
        else begin fail_cnt++; $error("disp_ready does not follow free space"); end
    a_disp_id: assert property (@(posedge clk) disable iff (rst) disp_id == m_tail)
        else begin fail_cnt++; $error("disp_id is not the next free entry"); end
    a_depth: assert property (@(posedge clk) disable iff (rst) m_count <= ROB_DEPTH)
        else begin fail_cnt++; $error("shadow count out of range"); end
    a_ncom: assert property (@(posedge clk) disable iff (rst) $countones(com_valid) == exp_ncom)
        else begin fail_cnt++; $error("wrong number of commits"); end
    a_slots: assert property (@(posedge clk) disable iff (rst) com_valid[1] |-> com_valid[0])
        else begin fail_cnt++; $error("commit slot 1 valid without slot 0"); end
    a_exc: assert property (@(posedge clk) disable iff (rst) exception == exp_exc)
        else begin fail_cnt++; $error("exception does not match the head entry"); end
    a_exc_data: assert property (@(posedge clk) disable iff (rst)
        exception |-> epc == m_pc[exp_idx] && cause == m_cause[exp_idx]
                      && tval == m_tval[exp_idx])
        else begin fail_cnt++; $error("wrong epc, cause or tval"); end
    a_pulse: assert property (@(posedge clk) disable iff (rst) exception |=> !exception)
        else begin fail_cnt++; $error("exception longer than one cycle"); end
    a_reopen: assert property (@(posedge clk) disable iff (rst) exception |=> disp_ready)
        else begin fail_cnt++; $error("dispatch not reopened after flush"); end

    for (genvar i = 0; i < COM_W; i++) begin : g_lane
        a_lane: assert property (@(posedge clk) disable iff (rst)
            com_valid[i] |-> com_id[i] == m_head + ROB_IDW'(i)
                             && com_pc[i] == m_pc[m_head + ROB_IDW'(i)])
            else begin fail_cnt++; $error("commit lane out of program order"); end
    end

endmodule

// File: dv/rob_tb.sv
`timescale 1ns/1ps

module rob_tb
    import rob_pkg::*;
();

    localparam int RESET_CYCLES = 8;
    localparam int ORDER_CYCLES = 300;
    localparam int FULL_CYCLES  = 40;
    localparam int EXC_CYCLES   = 400;
    localparam int DRAIN_LIMIT  = 100;                     // per test
    localparam int NUM_TESTS    = 4;
    localparam int WATCHDOG_NS  = (RESET_CYCLES + ORDER_CYCLES + FULL_CYCLES + EXC_CYCLES
                                   + NUM_TESTS * DRAIN_LIMIT) * 4 + 200;

    logic                           clk = 1'b0;
    logic                           rst;
    logic [DISP_W-1:0]              disp_valid;
    logic [DISP_W-1:0][PC_W-1:0]    disp_pc;
    logic                           disp_ready;
    logic [ROB_IDW-1:0]             disp_id;
    logic [EXE_W-1:0]               exe_valid;
    logic [EXE_W-1:0][ROB_IDW-1:0]  exe_id;
    logic [EXE_W-1:0]               exe_exc;
    logic [EXE_W-1:0][CAUSE_W-1:0]  exe_cause;
    logic [EXE_W-1:0][TVAL_W-1:0]   exe_tval;
    logic [COM_W-1:0]               com_valid;
    logic [COM_W-1:0][ROB_IDW-1:0]  com_id;
    logic [COM_W-1:0][PC_W-1:0]     com_pc;
    logic                           exception;
    logic [PC_W-1:0]                epc;
    logic [CAUSE_W-1:0]             cause;
    logic [TVAL_W-1:0]              tval;

    logic [31:0]        lfsr = 32'heb7e_94ec;
    logic [ROB_IDW-1:0] open_ids  [$];                     // allocated, not completed
    logic [ROB_IDW-1:0] in_flight [$];                     // program order, not retired
    logic [PC_W-1:0]    pc_of     [ROB_DEPTH];
    logic [CAUSE_W-1:0] cause_of  [ROB_DEPTH];
    logic [TVAL_W-1:0]  tval_of   [ROB_DEPTH];
    int                 direct_errs = 0;
    int                 tests_run = 0;
    string              test_name = "";

    rob_top DUT (.*);

    bind rob_top rob_properties u_props (.*);

    always #2 clk = ~clk;

    // one LFSR step per bit taken
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v    = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic check_value(input string what, input logic [63:0] exp,
                               input logic [63:0] act);
        if (exp !== act) begin
            direct_errs++;
            $display("[ERROR] %s: %s expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic run_cycle(input bit disp_on, input bit exe_on, input int exc_odds);
        int                 ncom;
        int                 pick;
        logic [ROB_IDW-1:0] id;
        @(posedge clk);
        #1;
        disp_valid = '0;
        exe_valid  = '0;
        exe_exc    = '0;
        ncom = 0;
        for (int i = 0; i < COM_W; i++) begin
            ncom += com_valid[i];
        end
        if (ncom > in_flight.size()) begin
            direct_errs++;
            $display("test %s: commit reported with nothing in flight", test_name);
            ncom = in_flight.size();
        end
        repeat (ncom) id = in_flight.pop_front();
        if (exception) begin
            if (in_flight.size() == 0) begin
                direct_errs++;
                $display("test %s: exception raised with nothing in flight", test_name);
            end else begin
                id = in_flight[0];                         // oldest entry left after commits
                check_value("epc", pc_of[id], epc);
                check_value("cause", cause_of[id], cause);
                check_value("tval", tval_of[id], tval);
            end
            in_flight.delete();
            open_ids.delete();
            return;
        end
        if (exe_on) begin
            for (int l = 0; l < EXE_W; l++) begin
                if (open_ids.size() != 0 && rand_bits(1)) begin
                    pick = int'(rand_bits(4)) % open_ids.size();
                    id   = open_ids[pick];
                    open_ids.delete(pick);
                    exe_valid[l] = 1'b1;
                    exe_id[l]    = id;
                    exe_exc[l]   = int'(rand_bits(4)) < exc_odds;
                    exe_cause[l] = CAUSE_W'(rand_bits(4));
                    exe_tval[l]  = rand_bits(64);
                    cause_of[id] = exe_cause[l];
                    tval_of[id]  = exe_tval[l];
                end
            end
        end
        // new entries only become completable after this edge
        if (disp_on) begin
            disp_valid[0] = rand_bits(2) != 0;
            disp_valid[1] = disp_valid[0] && rand_bits(1);
            for (int l = 0; l < DISP_W; l++) begin
                disp_pc[l] = rand_bits(62) << 2;
                if (disp_ready && disp_valid[l]) begin
                    id        = disp_id + ROB_IDW'(l);
                    pc_of[id] = disp_pc[l];
                    open_ids.push_back(id);
                    in_flight.push_back(id);
                end
            end
        end
    endtask

    task automatic run_test(input string name, input int cycles, input bit disp_on,
                            input bit exe_on, input int exc_odds);
        int errs_before;
        int drain;
        test_name   = name;
        errs_before = DUT.u_props.fail_cnt + direct_errs;
        repeat (cycles) run_cycle(disp_on, exe_on, exc_odds);
        drain = 0;
        while (in_flight.size() != 0 && drain < DRAIN_LIMIT) begin
            run_cycle(1'b0, 1'b1, 0);
            drain++;
        end
        if (in_flight.size() != 0) begin
            direct_errs++;
            $display("test %s: buffer did not drain in %0d cycles", name, DRAIN_LIMIT);
        end
        tests_run++;
        $display("test %s: %0d cycles, %0d errors", name, cycles + drain,
                 DUT.u_props.fail_cnt + direct_errs - errs_before);
    endtask

    initial begin
        int total;
        rst        = 1'b1;
        disp_valid = '0;
        disp_pc    = '0;
        exe_valid  = '0;
        exe_id     = '0;
        exe_exc    = '0;
        exe_cause  = '0;
        exe_tval   = '0;
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;
        run_test("reset", RESET_CYCLES, 1'b0, 1'b0, 0);
        run_test("in_order", ORDER_CYCLES, 1'b1, 1'b1, 0);
        run_test("full", FULL_CYCLES, 1'b1, 1'b0, 0);      // fill, then drain frees space
        run_test("exception", EXC_CYCLES, 1'b1, 1'b1, 2);
        total = DUT.u_props.fail_cnt + direct_errs;
        $display("summary: %0d tests, %0d assertion failures, %0d direct errors",
                 tests_run, DUT.u_props.fail_cnt, direct_errs);
        if (total == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #WATCHDOG_NS;
        $display("timeout: tests still running after %0d ns", WATCHDOG_NS);
        $display("Checks failed");
        $finish;
    end

endmodule

// File: rob_commit.f
verilog/rob_pkg.sv
verilog/rob_occupancy.sv
verilog/rob_entry_store.sv
verilog/rob_commit_select.sv
verilog/rob_trap_unit.sv
verilog/rob_top.sv
dv/rob_properties.sv
dv/rob_tb.sv
